/* host_mux.f */
+incdir+include
logic/host_mux_pkg.sv
logic/queue_if.sv
logic/req_queue.sv
logic/req_arbiter.sv
logic/rsp_router.sv
logic/host_mux_top.sv
verif/host_mux_clkgen.sv
verif/host_mux_tb.sv

/* include/host_mux_params.svh */
`ifndef HOST_MUX_PARAMS_SVH
`define HOST_MUX_PARAMS_SVH

// ====================
// port sharing
// ====================

// accelerator instances behind the host port, 1 to 4
`define HM_NUM_PORTS 2

// instance number carried in the top metadata bits
`define HM_TAG_BITS 2

// ====================
// host request fields
// ====================

`define HM_ADDR_BITS 42
`define HM_DATA_BITS 512
`define HM_MDATA_BITS 16

// request queues, 16 entries
`define HM_QUEUE_DEPTH_BITS 4

// free entries left when almfull rises
`define HM_ALMFULL_MARGIN 4

`endif

/* logic/host_mux_pkg.sv */
`default_nettype none

`include "host_mux_params.svh"

package host_mux_pkg;

    // ====================
    // basic fields
    // ====================

    // cache-line address
    typedef logic [`HM_ADDR_BITS-1:0] addr_t;

    // one full cache line
    typedef logic [`HM_DATA_BITS-1:0] data_t;

    // top bits hold the instance number on the host side
    typedef logic [`HM_MDATA_BITS-1:0] mdata_t;

    typedef logic [`HM_TAG_BITS-1:0] port_id_t;

    // ====================
    // requests
    // ====================

    // mdata sits in the low bits of both request types
    typedef struct packed
    {
        addr_t  addr;
        mdata_t mdata;
    } rd_req_t;

    typedef struct packed
    {
        addr_t  addr;
        data_t  data;
        mdata_t mdata;
    } wr_req_t;

endpackage

`default_nettype wire

/* logic/host_mux_top.sv */
`default_nettype none

`include "host_mux_params.svh"

module host_mux_top
    import host_mux_pkg::*;
(
    input  logic                     clk,
    input  logic                     arst_n,

    // instance read requests
    input  logic [`HM_NUM_PORTS-1:0] inst_rd_valid,
    input  rd_req_t                  inst_rd_req [`HM_NUM_PORTS],
    output logic [`HM_NUM_PORTS-1:0] inst_rd_almfull,

    // instance write requests
    input  logic [`HM_NUM_PORTS-1:0] inst_wr_valid,
    input  wr_req_t                  inst_wr_req [`HM_NUM_PORTS],
    output logic [`HM_NUM_PORTS-1:0] inst_wr_almfull,

    // instance responses
    output logic [`HM_NUM_PORTS-1:0] inst_rd_rsp_valid,
    output mdata_t                   inst_rd_rsp_mdata,
    output data_t                    inst_rd_rsp_data,
    output logic [`HM_NUM_PORTS-1:0] inst_wr_rsp_valid,
    output mdata_t                   inst_wr_rsp_mdata,

    // host request channels
    output logic                     rd_valid,
    output rd_req_t                  rd_req,
    input  logic                     rd_almfull,
    output logic                     wr_valid,
    output wr_req_t                  wr_req,
    input  logic                     wr_almfull,

    // host response channels
    input  logic                     rd_rsp_valid,
    input  mdata_t                   rd_rsp_mdata,
    input  data_t                    rd_rsp_data,
    input  logic                     wr_rsp_valid,
    input  mdata_t                   wr_rsp_mdata
);

    // ====================
    // request arbiters
    // ====================

    req_arbiter #(.req_t(rd_req_t)) u_rd_arbiter
    (
        .clk          (clk),
        .arst_n       (arst_n),
        .inst_valid   (inst_rd_valid),
        .inst_req     (inst_rd_req),
        .inst_almfull (inst_rd_almfull),
        .host_almfull (rd_almfull),
        .host_valid   (rd_valid),
        .host_req     (rd_req)
    );

    req_arbiter #(.req_t(wr_req_t)) u_wr_arbiter
    (
        .clk          (clk),
        .arst_n       (arst_n),
        .inst_valid   (inst_wr_valid),
        .inst_req     (inst_wr_req),
        .inst_almfull (inst_wr_almfull),
        .host_almfull (wr_almfull),
        .host_valid   (wr_valid),
        .host_req     (wr_req)
    );

    // ====================
    // response routing
    // ====================

    rsp_router u_rd_router
    (
        .clk            (clk),
        .arst_n         (arst_n),
        .host_rsp_valid (rd_rsp_valid),
        .host_rsp_mdata (rd_rsp_mdata),
        .host_rsp_data  (rd_rsp_data),
        .inst_rsp_valid (inst_rd_rsp_valid),
        .inst_rsp_mdata (inst_rd_rsp_mdata),
        .inst_rsp_data  (inst_rd_rsp_data)
    );

    // write responses carry no data
    rsp_router u_wr_router
    (
        .clk            (clk),
        .arst_n         (arst_n),
        .host_rsp_valid (wr_rsp_valid),
        .host_rsp_mdata (wr_rsp_mdata),
        .host_rsp_data  ('0),
        .inst_rsp_valid (inst_wr_rsp_valid),
        .inst_rsp_mdata (inst_wr_rsp_mdata),
        .inst_rsp_data  ()
    );
endmodule

`default_nettype wire

/* logic/queue_if.sv */
`default_nettype none

// link between an arbiter and one of its request queues
interface queue_if
#(
    parameter type req_t = logic
)
();
    logic push;
    req_t push_data;
    logic pop;
    req_t head;
    logic empty;
    logic almfull;

    modport queue
    (
        input  push, push_data, pop,
        output head, empty, almfull
    );

    modport ctrl
    (
        output push, push_data, pop,
        input  head, empty, almfull
    );
endinterface

`default_nettype wire

/* logic/req_arbiter.sv */
`default_nettype none

`include "host_mux_params.svh"

module req_arbiter
    import host_mux_pkg::*;
#(
    parameter type req_t = rd_req_t
)
(
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic [`HM_NUM_PORTS-1:0] inst_valid,
    input  req_t                     inst_req [`HM_NUM_PORTS],
    output logic [`HM_NUM_PORTS-1:0] inst_almfull,
    input  logic                     host_almfull,
    output logic                     host_valid,
    output req_t                     host_req
);
    localparam int N = `HM_NUM_PORTS;

    logic [N-1:0] q_empty;
    logic [N-1:0] q_pop;
    req_t         q_head [N];

    port_id_t ptr;
    port_id_t ptr_succ;
    port_id_t ptr_next;
    req_t     tagged_req;

    // ====================
    // per-port queues
    // ====================

    for (genvar i = 0; i < N; i++)
    begin : gen_port
        queue_if #(.req_t(req_t)) qif ();

        assign qif.push = inst_valid[i];
        assign qif.push_data = inst_req[i];
        assign qif.pop = q_pop[i];

        assign q_head[i] = qif.head;
        assign q_empty[i] = qif.empty;
        assign inst_almfull[i] = qif.almfull;

        // only the current port pops, and never under host back-pressure
        assign q_pop[i] = (ptr == port_id_t'(i)) && !qif.empty && !host_almfull;

        req_queue #(.req_t(req_t)) u_queue
        (
            .clk    (clk),
            .arst_n (arst_n),
            .q      (qif.queue)
        );
    end

    // ====================
    // rotating pointer
    // ====================

    assign ptr_succ = (ptr == port_id_t'(N - 1)) ? '0 : ptr + port_id_t'(1);

    always_comb
    begin
        // fallback is the highest non-empty port, else port 0
        ptr_next = '0;
        for (int i = 0; i < N; i++)
        begin
            if (!q_empty[i])
            begin
                ptr_next = port_id_t'(i);
            end
        end
        // next port in turn wins when it has work
        for (int i = 0; i < N; i++)
        begin
            if (port_id_t'(i) == ptr_succ && !q_empty[i])
            begin
                ptr_next = ptr_succ;
            end
        end
    end

    // selected head with the instance number in the top tag bits
    always_comb
    begin
        tagged_req = q_head[0];
        for (int i = 0; i < N; i++)
        begin
            if (port_id_t'(i) == ptr)
            begin
                tagged_req = q_head[i];
            end
        end
        tagged_req.mdata[`HM_MDATA_BITS-1 -: `HM_TAG_BITS] = ptr;
    end

    // ====================
    // host output register
    // ====================

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            ptr        <= '0;
            host_valid <= 1'b0;
        end
        else
        begin
            ptr        <= ptr_next;
            host_valid <= |q_pop;
        end
    end

    always_ff @(posedge clk)
    begin
        if (|q_pop)
        begin
            host_req <= tagged_req;
        end
    end

    // one request may still leave in the cycle almfull rises, none after
    assert property (@(posedge clk) disable iff (!arst_n) host_almfull |=> !host_valid)
        else $error("req_arbiter: host request issued under almost-full");
endmodule

`default_nettype wire

/* logic/req_queue.sv */
`default_nettype none

`include "host_mux_params.svh"

module req_queue
    import host_mux_pkg::*;
#(
    parameter type req_t = rd_req_t
)
(
    input logic    clk,
    input logic    arst_n,
    queue_if.queue q
);
    localparam int PTR_BITS = `HM_QUEUE_DEPTH_BITS;
    localparam int DEPTH = 1 << PTR_BITS;

    localparam logic [PTR_BITS-1:0] PTR_ONE = 1;
    localparam logic [PTR_BITS:0] CNT_ONE = 1;
    localparam logic [PTR_BITS:0] FULL_LEVEL = (PTR_BITS+1)'(DEPTH);
    localparam logic [PTR_BITS:0] ALMFULL_LEVEL = (PTR_BITS+1)'(DEPTH - `HM_ALMFULL_MARGIN);

    req_t                mem [DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [PTR_BITS:0]   count;

    // storage
    always_ff @(posedge clk)
    begin
        if (q.push)
        begin
            mem[wr_ptr] <= q.push_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (q.push)
            begin
                wr_ptr <= wr_ptr + PTR_ONE;
            end
            if (q.pop)
            begin
                rd_ptr <= rd_ptr + PTR_ONE;
            end
            case ({q.push, q.pop})
                2'b10:   count <= count + CNT_ONE;
                2'b01:   count <= count - CNT_ONE;
                default: count <= count;
            endcase
        end
    end

    // head is visible in the same cycle the arbiter pops it
    assign q.head = mem[rd_ptr];
    assign q.empty = (count == '0);
    assign q.almfull = (count >= ALMFULL_LEVEL);

    // the instance must stop pushing before the queue overflows
    assert property (@(posedge clk) disable iff (!arst_n)
        q.push && !q.pop |-> count != FULL_LEVEL)
        else $error("req_queue: push while full");

    assert property (@(posedge clk) disable iff (!arst_n) q.pop |-> !q.empty)
        else $error("req_queue: pop while empty");
endmodule

`default_nettype wire

/* logic/rsp_router.sv */
`default_nettype none

`include "host_mux_params.svh"

module rsp_router
    import host_mux_pkg::*;
(
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     host_rsp_valid,
    input  mdata_t                   host_rsp_mdata,
    input  data_t                    host_rsp_data,
    output logic [`HM_NUM_PORTS-1:0] inst_rsp_valid,
    output mdata_t                   inst_rsp_mdata,
    output data_t                    inst_rsp_data
);
    localparam int N = `HM_NUM_PORTS;

    port_id_t rsp_port;

    // instance number written by the arbiter on the way out
    assign rsp_port = host_rsp_mdata[`HM_MDATA_BITS-1 -: `HM_TAG_BITS];

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            inst_rsp_valid <= '0;
        end
        else
        begin
            for (int i = 0; i < N; i++)
            begin
                inst_rsp_valid[i] <= host_rsp_valid && (rsp_port == port_id_t'(i));
            end
        end
    end

    // metadata and data are shared by all instances
    always_ff @(posedge clk)
    begin
        inst_rsp_mdata <= host_rsp_mdata;
        inst_rsp_data  <= host_rsp_data;
    end

    assert property (@(posedge clk) disable iff (!arst_n) $onehot0(inst_rsp_valid))
        else $error("rsp_router: response sent to more than one instance");
endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# compile and run the host_mux testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module host_mux_tb -f host_mux.f -o host_mux_sim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

sim_out=$(./obj_dir/host_mux_sim 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Result: PASSED" <<< "$sim_out"; then
    exit 0
fi
exit 1

/* verif/host_mux_clkgen.sv */
`default_nettype none

// free-running clock and power-on reset for the testbench
module host_mux_clkgen
(
    output logic clk,
    output logic arst_n
);
    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // reset held for four clock cycles
    initial
    begin
        arst_n = 1'b0;
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
    end
endmodule

`default_nettype wire

/* verif/host_mux_tb.sv */
`default_nettype none

`include "host_mux_params.svh"

module host_mux_tb
    import host_mux_pkg::*;
();
    localparam int N = `HM_NUM_PORTS;
    localparam int ALMFULL_LEVEL = (1 << `HM_QUEUE_DEPTH_BITS) - `HM_ALMFULL_MARGIN;

    typedef logic [N-1:0] mask_t;

    logic    clk;
    logic    arst_n;
    mask_t   inst_rd_valid;
    rd_req_t inst_rd_req [N];
    mask_t   inst_rd_almfull;
    mask_t   inst_wr_valid;
    wr_req_t inst_wr_req [N];
    mask_t   inst_wr_almfull;
    mask_t   inst_rd_rsp_valid;
    mdata_t  inst_rd_rsp_mdata;
    data_t   inst_rd_rsp_data;
    mask_t   inst_wr_rsp_valid;
    mdata_t  inst_wr_rsp_mdata;
    logic    rd_valid;
    rd_req_t rd_req;
    logic    rd_almfull;
    logic    wr_valid;
    wr_req_t wr_req;
    logic    wr_almfull;
    logic    rd_rsp_valid;
    mdata_t  rd_rsp_mdata;
    data_t   rd_rsp_data;
    logic    wr_rsp_valid;
    mdata_t  wr_rsp_mdata;

    int      seed = 32'h6df;
    int      mismatches = 0;
    int      failures = 0;
    string   test_name = "init";

    // requests the host side should see, already tagged
    rd_req_t exp_rd [$];
    wr_req_t exp_wr [$];

    host_mux_clkgen u_clkgen
    (
        .clk    (clk),
        .arst_n (arst_n)
    );

    host_mux_top dut0 (.*);

    // ====================
    // stimulus helpers
    // ====================

    function automatic addr_t rand_addr();
        logic [63:0] r;
        r = {$random(seed), $random(seed)};
        return r[`HM_ADDR_BITS-1:0];
    endfunction

    function automatic data_t rand_data();
        data_t d;
        for (int i = 0; i < `HM_DATA_BITS / 32; i++)
        begin
            d[32*i +: 32] = $random(seed);
        end
        return d;
    endfunction

    function automatic mdata_t rand_mdata();
        logic [31:0] r;
        r = $random(seed);
        return r[`HM_MDATA_BITS-1:0];
    endfunction

    // instance number replaces the top metadata bits
    function automatic mdata_t tag_mdata(input mdata_t m, input port_id_t p);
        mdata_t t;
        t = m;
        t[`HM_MDATA_BITS-1 -: `HM_TAG_BITS] = p;
        return t;
    endfunction

    // oldest pending request of one port
    function automatic int find_rd(input port_id_t p);
        for (int i = 0; i < exp_rd.size(); i++)
        begin
            if (exp_rd[i].mdata[`HM_MDATA_BITS-1 -: `HM_TAG_BITS] == p)
            begin
                return i;
            end
        end
        return -1;
    endfunction

    function automatic int find_wr(input port_id_t p);
        for (int i = 0; i < exp_wr.size(); i++)
        begin
            if (exp_wr[i].mdata[`HM_MDATA_BITS-1 -: `HM_TAG_BITS] == p)
            begin
                return i;
            end
        end
        return -1;
    endfunction

    task automatic init_inputs();
        inst_rd_valid <= '0;
        inst_wr_valid <= '0;
        for (int p = 0; p < N; p++)
        begin
            inst_rd_req[p] <= '0;
            inst_wr_req[p] <= '0;
        end
        rd_almfull   <= 1'b0;
        wr_almfull   <= 1'b0;
        rd_rsp_valid <= 1'b0;
        rd_rsp_mdata <= '0;
        rd_rsp_data  <= '0;
        wr_rsp_valid <= 1'b0;
        wr_rsp_mdata <= '0;
    endtask

    // one cycle of read pushes from the selected ports
    task automatic drive_reads(input mask_t ports);
        rd_req_t req;
        rd_req_t exp;
        @(posedge clk);
        for (int p = 0; p < N; p++)
        begin
            if (ports[p])
            begin
                req.addr  = rand_addr();
                req.mdata = rand_mdata();
                exp = req;
                exp.mdata = tag_mdata(req.mdata, port_id_t'(p));
                exp_rd.push_back(exp);
                inst_rd_req[p] <= req;
            end
        end
        inst_rd_valid <= ports;
    endtask

    task automatic drive_write(input int p);
        wr_req_t req;
        wr_req_t exp;
        @(posedge clk);
        req.addr  = rand_addr();
        req.data  = rand_data();
        req.mdata = rand_mdata();
        exp = req;
        exp.mdata = tag_mdata(req.mdata, port_id_t'(p));
        exp_wr.push_back(exp);
        inst_wr_req[p] <= req;
        inst_wr_valid  <= mask_t'(1) << p;
    endtask

    task automatic idle_requests();
        @(posedge clk);
        inst_rd_valid <= '0;
        inst_wr_valid <= '0;
    endtask

    // ====================
    // compare tasks
    // ====================

    task automatic check_rd_req(input rd_req_t exp, input rd_req_t act);
        if (act !== exp)
        begin
            mismatches++;
            $display("Mismatch in %s: expected %h, actual %h", test_name, exp, act);
        end
    endtask

    task automatic check_wr_req(input wr_req_t exp, input wr_req_t act);
        if (act !== exp)
        begin
            mismatches++;
            $display("Mismatch in %s: expected %h, actual %h", test_name, exp, act);
        end
    endtask

    task automatic check_rsp(input mdata_t exp_m, input data_t exp_d,
                             input mdata_t act_m, input data_t act_d);
        if (act_m !== exp_m || act_d !== exp_d)
        begin
            mismatches++;
            $display("Mismatch in %s: expected %h/%h, actual %h/%h",
                     test_name, exp_m, exp_d, act_m, act_d);
        end
    endtask

    task automatic check_mask(input string what, input mask_t exp, input mask_t act);
        if (act !== exp)
        begin
            mismatches++;
            $display("Mismatch in %s (%s): expected %b, actual %b", test_name, what, exp, act);
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (act !== exp)
        begin
            mismatches++;
            $display("Mismatch in %s (%s): expected %b, actual %b", test_name, what, exp, act);
        end
    endtask

    // host side, matched per port by the tag
    always @(negedge clk)
    begin : host_monitor
        int idx;
        if (arst_n)
        begin
            if (rd_valid)
            begin
                idx = find_rd(rd_req.mdata[`HM_MDATA_BITS-1 -: `HM_TAG_BITS]);
                if (idx < 0)
                begin
                    failures++;
                    $display("ERROR in %s: unexpected host read request %h", test_name, rd_req);
                end
                else
                begin
                    check_rd_req(exp_rd[idx], rd_req);
                    exp_rd.delete(idx);
                end
            end
            if (wr_valid)
            begin
                idx = find_wr(wr_req.mdata[`HM_MDATA_BITS-1 -: `HM_TAG_BITS]);
                if (idx < 0)
                begin
                    failures++;
                    $display("ERROR in %s: unexpected host write request %h", test_name, wr_req);
                end
                else
                begin
                    check_wr_req(exp_wr[idx], wr_req);
                    exp_wr.delete(idx);
                end
            end
        end
    end

    task automatic wait_drain(input int limit);
        int cycles;
        cycles = 0;
        while ((exp_rd.size() != 0 || exp_wr.size() != 0) && cycles < limit)
        begin
            @(negedge clk);
            cycles++;
        end
        if (exp_rd.size() != 0 || exp_wr.size() != 0)
        begin
            failures++;
            $display("ERROR in %s: timed out with %0d reads and %0d writes never reaching the host",
                     test_name, exp_rd.size(), exp_wr.size());
        end
    endtask

    // ====================
    // directed tests
    // ====================

    task automatic test_reset();
        int cycles;
        test_name = "reset";
        cycles = 0;
        @(negedge clk);
        check_flag("rd_valid", 1'b0, rd_valid);
        check_flag("wr_valid", 1'b0, wr_valid);
        check_mask("inst_rd_almfull", '0, inst_rd_almfull);
        check_mask("inst_wr_almfull", '0, inst_wr_almfull);
        check_mask("inst_rd_rsp_valid", '0, inst_rd_rsp_valid);
        check_mask("inst_wr_rsp_valid", '0, inst_wr_rsp_valid);
        while (!arst_n && cycles < 20)
        begin
            @(negedge clk);
            cycles++;
        end
        if (!arst_n)
        begin
            failures++;
            $display("ERROR in %s: reset was never released", test_name);
        end
    endtask

    task automatic test_single_read();
        test_name = "single_read";
        drive_reads(mask_t'(2));
        idle_requests();
        wait_drain(40);
    endtask

    task automatic test_read_burst();
        test_name = "read_burst";
        repeat (6) drive_reads('1);
        idle_requests();
        wait_drain(100);
    endtask

    task automatic test_write_backpressure();
        test_name = "write_backpressure";
        @(posedge clk);
        wr_almfull <= 1'b1;
        repeat (2) @(posedge clk);
        // queue fills up to the margin while the host holds off
        for (int k = 0; k < ALMFULL_LEVEL; k++)
        begin
            drive_write(0);
            @(negedge clk);
            check_flag("wr_valid", 1'b0, wr_valid);
            check_mask("inst_wr_almfull", '0, inst_wr_almfull);
        end
        idle_requests();
        @(negedge clk);
        check_flag("wr_valid", 1'b0, wr_valid);
        check_mask("inst_wr_almfull", mask_t'(1), inst_wr_almfull);
        @(posedge clk);
        wr_almfull <= 1'b0;
        wait_drain(200);
        @(negedge clk);
        check_mask("inst_wr_almfull", '0, inst_wr_almfull);
    endtask

    task automatic test_responses();
        mdata_t rd_m;
        mdata_t wr_m;
        data_t  rd_d;
        test_name = "responses";
        for (int i = 0; i < N; i++)
        begin
            rd_m = tag_mdata(rand_mdata(), port_id_t'(i));
            wr_m = tag_mdata(rand_mdata(), port_id_t'(N - 1 - i));
            rd_d = rand_data();
            @(posedge clk);
            rd_rsp_valid <= 1'b1;
            rd_rsp_mdata <= rd_m;
            rd_rsp_data  <= rd_d;
            wr_rsp_valid <= 1'b1;
            wr_rsp_mdata <= wr_m;
            @(posedge clk);
            rd_rsp_valid <= 1'b0;
            wr_rsp_valid <= 1'b0;
            @(negedge clk);
            check_mask("inst_rd_rsp_valid", mask_t'(1) << i, inst_rd_rsp_valid);
            check_mask("inst_wr_rsp_valid", mask_t'(1) << (N - 1 - i), inst_wr_rsp_valid);
            check_rsp(rd_m, rd_d, inst_rd_rsp_mdata, inst_rd_rsp_data);
            // write responses carry no data
            check_rsp(wr_m, '0, inst_wr_rsp_mdata, '0);
            @(negedge clk);
            check_mask("inst_rd_rsp_valid", '0, inst_rd_rsp_valid);
            check_mask("inst_wr_rsp_valid", '0, inst_wr_rsp_valid);
        end
    endtask

    initial
    begin
        init_inputs();
        test_reset();
        test_single_read();
        test_read_burst();
        test_write_backpressure();
        test_responses();
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0)
        begin
            $display("Result: PASSED");
        end
        else
        begin
            $display("Result: FAILED");
        end
        $finish;
    end
endmodule

`default_nettype wire
